//--- hdl/vregunpack_consts.svh
/* widths and counts of the operand unpack pipeline
   included by the RTL and the testbench wherever a size is needed */
`ifndef VREGUNPACK_CONSTS_SVH
`define VREGUNPACK_CONSTS_SVH
`default_nettype none

// register file read port
`define VREG_W         64   // read port and operand width
`define VADDR_W        5
`define VREG_CNT       32   // also the width of the pending read mask

// width of the control word carried alongside the operands
`define CTRL_W         8

// pipeline shape
`define UNPACK_STAGES  3
`define LOAD_STAGE     1    // stage that addresses the register file

`default_nettype wire
`endif

//--- hdl/vregunpack_pkg.sv
/* types shared by the unpack pipeline, its units and the testbench
   element width, operand flags and the byte/halfword/word view of one register word */
`include "vregunpack_consts.svh"
`default_nettype none

package vregunpack_pkg;

    // element width of the current instruction
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // per-operand unpack flags
    typedef struct packed {
        logic vreg;    // operand comes from a vector register, not the scalar
        logic narrow;  // half width elements, extend to full width
        logic sigext;  // sign extension instead of zero extension
    } op_flags_t;

    // one register word seen as bytes, halfwords or words
    typedef union packed {
        logic [`VREG_W/8-1:0][7:0]   b;
        logic [`VREG_W/16-1:0][15:0] h;
        logic [`VREG_W/32-1:0][31:0] w;
    } vreg_word_u;

endpackage

`default_nettype wire

//--- hdl/unpack_stage_if.sv
/* load and extract controls passed from the pipeline to the unpack units
   the pipeline drives everything, the units only listen */
`default_nettype none

interface unpack_stage_if;
    import vregunpack_pkg::*;

    logic        load_en;        // stage 1 valid and moving into stage 2
    eew_e        load_eew;
    logic        load_op;
    logic        load_mask;
    eew_e        extract_eew;
    op_flags_t   extract_flags;
    logic [31:0] extract_xval;
    logic        out_en;         // stage 3 takes over stage 2

    modport pipeline (
        output load_en, load_eew, load_op, load_mask,
        output extract_eew, extract_flags, extract_xval, out_en
    );

    modport unit (
        input load_en, load_eew, load_op, load_mask,
        input extract_eew, extract_flags, extract_xval, out_en
    );

endinterface

`default_nettype wire

//--- hdl/unpack_pipeline.sv
/* stage control of the unpack pipeline
   keeps the per-stage valid bits and state, builds the ready chain, addresses the
   register file from the load stage and reports registers that still await a read */
`include "vregunpack_consts.svh"
`default_nettype none

module unpack_pipeline (
    input  logic                       clk_i,
    input  logic                       async_rst_ni,
    input  logic                       pipe_in_valid_i,
    output logic                       pipe_in_ready_o,
    input  logic [`CTRL_W-1:0]         pipe_in_ctrl_i,
    input  vregunpack_pkg::eew_e       pipe_in_eew_i,
    input  logic                       pipe_in_op_load_i,
    input  logic                       pipe_in_mask_load_i,
    input  logic [`VADDR_W-1:0]        pipe_in_vaddr_i,
    input  vregunpack_pkg::op_flags_t  pipe_in_flags_i,
    input  logic [31:0]                pipe_in_xval_i,
    output logic                       pipe_out_valid_o,
    input  logic                       pipe_out_ready_i,
    output logic [`CTRL_W-1:0]         pipe_out_ctrl_o,
    output logic [`VADDR_W-1:0]        vreg_rd_addr_o,
    output logic [`VREG_CNT-1:0]       pending_vreg_reads_o,
    unpack_stage_if.pipeline           stage
);
    import vregunpack_pkg::*;

    localparam int unsigned NSTAGES  = `UNPACK_STAGES;
    localparam int unsigned LD_STAGE = `LOAD_STAGE;
    localparam int unsigned EX_STAGE = `LOAD_STAGE + 1;  // buffers are read here

    logic [NSTAGES:1]     valid_q;
    logic [NSTAGES:1]     accept;     // stage loads from the one before on this edge
    logic [`CTRL_W-1:0]   ctrl_q [1:NSTAGES];
    eew_e                 eew_q [1:EX_STAGE];
    op_flags_t            flags_q [1:EX_STAGE];
    logic [31:0]          xval_q [1:EX_STAGE];
    logic [LD_STAGE:1]    op_load_q;
    logic [LD_STAGE:1]    mask_load_q;
    logic [`VADDR_W-1:0]  vaddr_q [1:LD_STAGE];
    logic [LD_STAGE:1]    stage_rd;   // stage holds a register read
    logic                 in_rd;

    // a stage may take new data when the output drains or a bubble sits at or after it
    always_comb begin
        for (int i = 1; i <= NSTAGES; i++) begin
            accept[i] = pipe_out_ready_i;
            for (int j = i; j <= NSTAGES; j++) begin
                if (!valid_q[j]) begin
                    accept[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= '0;
        end else begin
            if (accept[1]) begin
                valid_q[1] <= pipe_in_valid_i;
            end
            for (int i = 2; i <= NSTAGES; i++) begin
                if (accept[i]) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end
    end

    // stage payload, each field kept only as far as it is needed
    always_ff @(posedge clk_i) begin
        if (accept[1]) begin
            ctrl_q[1]      <= pipe_in_ctrl_i;
            eew_q[1]       <= pipe_in_eew_i;
            flags_q[1]     <= pipe_in_flags_i;
            xval_q[1]      <= pipe_in_xval_i;
            op_load_q[1]   <= pipe_in_op_load_i;
            mask_load_q[1] <= pipe_in_mask_load_i;
            vaddr_q[1]     <= pipe_in_vaddr_i;
        end
        for (int i = 2; i <= NSTAGES; i++) begin
            if (accept[i]) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
        for (int i = 2; i <= EX_STAGE; i++) begin
            if (accept[i]) begin
                eew_q[i]   <= eew_q[i-1];
                flags_q[i] <= flags_q[i-1];
                xval_q[i]  <= xval_q[i-1];
            end
        end
    end

    assign pipe_in_ready_o  = accept[1];
    assign pipe_out_valid_o = valid_q[NSTAGES];
    assign pipe_out_ctrl_o  = ctrl_q[NSTAGES];

    // register reads only for valid operand loads that name a vector register
    assign in_rd = pipe_in_valid_i & pipe_in_op_load_i & pipe_in_flags_i.vreg;
    always_comb begin
        for (int i = 1; i <= LD_STAGE; i++) begin
            stage_rd[i] = valid_q[i] & op_load_q[i] & flags_q[i].vreg;
        end
    end

    assign vreg_rd_addr_o = stage_rd[LD_STAGE] ? vaddr_q[LD_STAGE] : '0;

    always_comb begin
        pending_vreg_reads_o = '0;
        if (in_rd) begin
            pending_vreg_reads_o[pipe_in_vaddr_i] = 1'b1;
        end
        for (int i = 1; i <= LD_STAGE; i++) begin
            if (stage_rd[i]) begin
                pending_vreg_reads_o[vaddr_q[i]] = 1'b1;
            end
        end
    end

    // controls for the unpack units
    assign stage.load_en       = valid_q[LD_STAGE] & accept[LD_STAGE+1];
    assign stage.load_eew      = eew_q[LD_STAGE];
    assign stage.load_op       = op_load_q[LD_STAGE];
    assign stage.load_mask     = mask_load_q[LD_STAGE];
    assign stage.extract_eew   = eew_q[EX_STAGE];
    assign stage.extract_flags = flags_q[EX_STAGE];
    assign stage.extract_xval  = xval_q[EX_STAGE];
    assign stage.out_en        = accept[EX_STAGE+1];  // result register is the last stage

endmodule

`default_nettype wire

//--- hdl/operand_unpack.sv
/* vector operand unit
   buffers the register word read in the load stage, then extends narrow elements or
   replicates the scalar, and registers the result as the output operand */
`include "vregunpack_consts.svh"
`default_nettype none

module operand_unpack (
    input  logic               clk_i,
    input  logic [`VREG_W-1:0] vreg_rd_data_i,
    unpack_stage_if.unit       stage,
    output logic [`VREG_W-1:0] op_o
);
    import vregunpack_pkg::*;

    vreg_word_u op_buf_q;
    vreg_word_u op_ext;
    logic       sx;

    // buffer keeps its word until the next operand load
    always_ff @(posedge clk_i) begin
        if (stage.load_en && stage.load_op) begin
            op_buf_q <= vreg_rd_data_i;
        end
    end

    assign sx = stage.extract_flags.sigext;

    always_comb begin
        op_ext = '0;
        if (!stage.extract_flags.vreg) begin
            // scalar operand, low element bits of xval in every lane
            case (stage.extract_eew)
                EEW_8: begin
                    for (int i = 0; i < `VREG_W / 8; i++) begin
                        op_ext.b[i] = stage.extract_xval[7:0];
                    end
                end
                EEW_16: begin
                    for (int i = 0; i < `VREG_W / 16; i++) begin
                        op_ext.h[i] = stage.extract_xval[15:0];
                    end
                end
                EEW_32: begin
                    for (int i = 0; i < `VREG_W / 32; i++) begin
                        op_ext.w[i] = stage.extract_xval;
                    end
                end
                default: ;
            endcase
        end else if (stage.extract_flags.narrow) begin
            // lower half of the word holds the narrow elements
            case (stage.extract_eew)
                EEW_16: begin
                    for (int i = 0; i < `VREG_W / 16; i++) begin
                        op_ext.h[i] = {{8{sx & op_buf_q.b[i][7]}}, op_buf_q.b[i]};
                    end
                end
                EEW_32: begin
                    for (int i = 0; i < `VREG_W / 32; i++) begin
                        op_ext.w[i] = {{16{sx & op_buf_q.h[i][15]}}, op_buf_q.h[i]};
                    end
                end
                default: ;  // no narrower source for byte elements
            endcase
        end else begin
            op_ext = op_buf_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage.out_en) begin
            op_o <= op_ext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mask_unpack.sv
/* mask unit
   buffers v0 in the load stage and spreads each element mask bit over the
   byte lanes of its element, one output bit per byte */
`include "vregunpack_consts.svh"
`default_nettype none

module mask_unpack (
    input  logic               clk_i,
    input  logic [`VREG_W-1:0] vreg_rd_v0_i,
    unpack_stage_if.unit       stage,
    output logic [`VREG_W-1:0] mask_o
);
    import vregunpack_pkg::*;

    logic [`VREG_W-1:0] elem_keep;   // mask bits that map to a byte lane
    logic [`VREG_W-1:0] mask_buf_q;
    logic [`VREG_W-1:0] mask_ext;

    // bits beyond the last element that fits are cleared on load
    always_comb begin
        elem_keep = '0;
        case (stage.load_eew)
            EEW_8:   elem_keep = '1;
            EEW_16:  elem_keep[`VREG_W/2-1:0] = '1;
            EEW_32:  elem_keep[`VREG_W/4-1:0] = '1;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (stage.load_en && stage.load_mask) begin
            mask_buf_q <= vreg_rd_v0_i & elem_keep;
        end
    end

    always_comb begin
        mask_ext = '0;
        case (stage.extract_eew)
            EEW_8: mask_ext = mask_buf_q;  // already one bit per byte
            EEW_16: begin
                for (int j = 0; j < `VREG_W / 2; j++) begin
                    mask_ext[2*j +: 2] = {2{mask_buf_q[j]}};
                end
            end
            EEW_32: begin
                for (int j = 0; j < `VREG_W / 4; j++) begin
                    mask_ext[4*j +: 4] = {4{mask_buf_q[j]}};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (stage.out_en) begin
            mask_o <= mask_ext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vregunpack_top.sv
/* top level of the operand unpack pipeline
   connects the stage control to the operand and mask units through one stage interface */
`include "vregunpack_consts.svh"
`default_nettype none

module vregunpack_top (
    input  logic                       clk_i,
    input  logic                       async_rst_ni,
    output logic [`VADDR_W-1:0]        vreg_rd_addr_o,
    input  logic [`VREG_W-1:0]         vreg_rd_data_i,
    input  logic [`VREG_W-1:0]         vreg_rd_v0_i,
    input  logic                       pipe_in_valid_i,
    output logic                       pipe_in_ready_o,
    input  logic [`CTRL_W-1:0]         pipe_in_ctrl_i,
    input  vregunpack_pkg::eew_e       pipe_in_eew_i,
    input  logic                       pipe_in_op_load_i,
    input  logic                       pipe_in_mask_load_i,
    input  logic [`VADDR_W-1:0]        pipe_in_vaddr_i,
    input  vregunpack_pkg::op_flags_t  pipe_in_flags_i,
    input  logic [31:0]                pipe_in_xval_i,
    output logic                       pipe_out_valid_o,
    input  logic                       pipe_out_ready_i,
    output logic [`CTRL_W-1:0]         pipe_out_ctrl_o,
    output logic [`VREG_W-1:0]         pipe_out_op_o,
    output logic [`VREG_W-1:0]         pipe_out_mask_o,
    output logic [`VREG_CNT-1:0]       pending_vreg_reads_o
);

    unpack_stage_if stage_if ();

    unpack_pipeline pipe0 (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .pipe_in_valid_i      (pipe_in_valid_i),
        .pipe_in_ready_o      (pipe_in_ready_o),
        .pipe_in_ctrl_i       (pipe_in_ctrl_i),
        .pipe_in_eew_i        (pipe_in_eew_i),
        .pipe_in_op_load_i    (pipe_in_op_load_i),
        .pipe_in_mask_load_i  (pipe_in_mask_load_i),
        .pipe_in_vaddr_i      (pipe_in_vaddr_i),
        .pipe_in_flags_i      (pipe_in_flags_i),
        .pipe_in_xval_i       (pipe_in_xval_i),
        .pipe_out_valid_o     (pipe_out_valid_o),
        .pipe_out_ready_i     (pipe_out_ready_i),
        .pipe_out_ctrl_o      (pipe_out_ctrl_o),
        .vreg_rd_addr_o       (vreg_rd_addr_o),
        .pending_vreg_reads_o (pending_vreg_reads_o),
        .stage                (stage_if)
    );

    operand_unpack op_unpack0 (
        .clk_i          (clk_i),
        .vreg_rd_data_i (vreg_rd_data_i),
        .stage          (stage_if),
        .op_o           (pipe_out_op_o)
    );

    mask_unpack mask_unpack0 (
        .clk_i        (clk_i),
        .vreg_rd_v0_i (vreg_rd_v0_i),
        .stage        (stage_if),
        .mask_o       (pipe_out_mask_o)
    );

endmodule

`default_nettype wire

//--- testbench/vregunpack_properties.sv
/* concurrent checks on the output handshake and the register read address
   attached to the top level by the bind below */
`include "vregunpack_consts.svh"
`default_nettype none

module vregunpack_properties (
    input logic                      clk_i,
    input logic                      async_rst_ni,
    input logic                      pipe_in_valid_i,
    input logic                      pipe_in_ready_o,
    input logic                      pipe_in_op_load_i,
    input logic [`VADDR_W-1:0]       pipe_in_vaddr_i,
    input vregunpack_pkg::op_flags_t pipe_in_flags_i,
    input logic                      pipe_out_valid_o,
    input logic                      pipe_out_ready_i,
    input logic [`CTRL_W-1:0]        pipe_out_ctrl_o,
    input logic [`VREG_W-1:0]        pipe_out_op_o,
    input logic [`VREG_W-1:0]        pipe_out_mask_o,
    input logic [`VADDR_W-1:0]       vreg_rd_addr_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                s1_rd;    // load stage holds a register read
    logic [`VADDR_W-1:0] s1_addr;

    // load stage occupancy rebuilt from the input handshake
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_rd   <= 1'b0;
            s1_addr <= '0;
        end else if (pipe_in_ready_o) begin
            s1_rd   <= pipe_in_valid_i && pipe_in_op_load_i && pipe_in_flags_i.vreg;
            s1_addr <= pipe_in_vaddr_i;
        end
    end

    // a stalled output item stays in place
    stall_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        pipe_out_valid_o && !pipe_out_ready_i |=> pipe_out_valid_o
            && $stable(pipe_out_ctrl_o) && $stable(pipe_out_op_o) && $stable(pipe_out_mask_o))
        else $error("output item changed while output ready was low");

    idle_addr: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !s1_rd |-> vreg_rd_addr_o == '0)
        else $error("read address not zero while no read is made");

    read_addr: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        s1_rd |-> vreg_rd_addr_o == s1_addr)
        else $error("read address differs from the load stage register");

    reset_idle: assert property (@(posedge clk_i) $rose(async_rst_ni) |-> !pipe_out_valid_o)
        else $error("output valid high right after reset");

endmodule

bind vregunpack_top vregunpack_properties props0 (.*);

`default_nettype wire

//--- testbench/vregunpack_tb.sv
/* testbench for the operand unpack pipeline
   drives random items through a register file model and compares each output
   item with a reference model of the unpack rules */
`include "vregunpack_consts.svh"
`default_nettype none

module vregunpack_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vregunpack_pkg::*;

    localparam int unsigned N_ITEMS = 240;  // sum of the phase lengths below

    typedef struct packed {
        logic [`CTRL_W-1:0] ctrl;
        logic [`VREG_W-1:0] op;
        logic [`VREG_W-1:0] mask;
    } item_exp_t;

    logic                 clk_i;
    logic                 async_rst_ni;
    logic [`VADDR_W-1:0]  vreg_rd_addr_o;
    logic [`VREG_W-1:0]   vreg_rd_data_i;
    logic [`VREG_W-1:0]   vreg_rd_v0_i;
    logic                 pipe_in_valid_i;
    logic                 pipe_in_ready_o;
    logic [`CTRL_W-1:0]   pipe_in_ctrl_i;
    eew_e                 pipe_in_eew_i;
    logic                 pipe_in_op_load_i;
    logic                 pipe_in_mask_load_i;
    logic [`VADDR_W-1:0]  pipe_in_vaddr_i;
    op_flags_t            pipe_in_flags_i;
    logic [31:0]          pipe_in_xval_i;
    logic                 pipe_out_valid_o;
    logic                 pipe_out_ready_i;
    logic [`CTRL_W-1:0]   pipe_out_ctrl_o;
    logic [`VREG_W-1:0]   pipe_out_op_o;
    logic [`VREG_W-1:0]   pipe_out_mask_o;
    logic [`VREG_CNT-1:0] pending_vreg_reads_o;

    logic [`VREG_W-1:0]   regs [`VREG_CNT];  // register file model
    logic [`VREG_W-1:0]   op_buf_m;          // last word the operand buffer took
    item_exp_t            exp_q [$];
    item_exp_t            want;
    int unsigned          value_errors = 0;
    int unsigned          other_errors = 0;
    string                cur_test;
    logic                 stall_mode;
    logic [3:1]           slot_v;            // stage occupancy seen from outside
    logic [3:1]           acc;
    logic                 slot1_rd;
    logic [`VADDR_W-1:0]  slot1_addr;
    logic [`VREG_CNT-1:0] exp_pend;

    vregunpack_top dut0 (.*);

    assign vreg_rd_data_i = regs[vreg_rd_addr_o];  // combinational read

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        pipe_out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            pipe_out_ready_i = stall_mode ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    initial begin
        repeat (N_ITEMS * 20 + 100) @(posedge clk_i);
        $display("timeout: the pipeline stopped delivering items in test %s", cur_test);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    // expected output item, built bit by bit from the unpack rules
    function automatic item_exp_t ref_unpack(input logic [`CTRL_W-1:0] ctrl,
                                             input logic [63:0] word, input logic [63:0] v0w,
                                             input eew_e eew, input op_flags_t fl,
                                             input logic [31:0] x);
        item_exp_t r;
        int        sh;
        int        w;
        int        hw;
        r.ctrl = ctrl;
        r.op   = '0;
        sh = (eew == EEW_8) ? 0 : (eew == EEW_16) ? 1 : 2;
        w  = 8 << sh;   // element width in bits
        hw = 4 << sh;
        if (!fl.vreg) begin
            for (int i = 0; i < 64; i++) r.op[i] = x[i % w];
        end else if (fl.narrow && sh > 0) begin
            for (int i = 0; i < 64; i++) begin
                if (i % w < hw) r.op[i] = word[(i / w) * hw + i % w];
                else r.op[i] = fl.sigext & word[(i / w) * hw + hw - 1];
            end
        end else if (!fl.narrow) begin
            r.op = word;
        end
        for (int k = 0; k < 64; k++) r.mask[k] = v0w[k >> sh];
        return r;
    endfunction

    // compare process, sampled at the falling edge where everything is settled
    always @(negedge clk_i) begin
        if (!async_rst_ni) begin
            slot_v = '0;
            check_value("out_valid", 64'(1'b0), 64'(pipe_out_valid_o));
            check_value("in_ready", 64'(1'b1), 64'(pipe_in_ready_o));
            check_value("pending", 64'(1'b0), 64'(pending_vreg_reads_o));
            check_value("rd_addr", 64'(1'b0), 64'(vreg_rd_addr_o));
        end else begin
            for (int i = 1; i <= 3; i++) begin
                acc[i] = pipe_out_ready_i;
                for (int j = i; j <= 3; j++) if (!slot_v[j]) acc[i] = 1'b1;
            end
            exp_pend = '0;
            if (pipe_in_valid_i && pipe_in_op_load_i && pipe_in_flags_i.vreg)
                exp_pend[pipe_in_vaddr_i] = 1'b1;
            if (slot_v[1] && slot1_rd) exp_pend[slot1_addr] = 1'b1;
            check_value("pending", 64'(exp_pend), 64'(pending_vreg_reads_o));
            check_value("in_ready", 64'(acc[1]), 64'(pipe_in_ready_o));
            check_value("out_valid", 64'(slot_v[3]), 64'(pipe_out_valid_o));
            if (pipe_in_valid_i && pipe_in_ready_o) begin
                // read address is zero when the item names no register
                if (pipe_in_op_load_i)
                    op_buf_m = regs[pipe_in_flags_i.vreg ? pipe_in_vaddr_i : 5'd0];
                exp_q.push_back(ref_unpack(pipe_in_ctrl_i, op_buf_m, vreg_rd_v0_i,
                                           pipe_in_eew_i, pipe_in_flags_i, pipe_in_xval_i));
            end
            if (pipe_out_valid_o && pipe_out_ready_i) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("output item delivered with none outstanding in test %s", cur_test);
                end else begin
                    want = exp_q.pop_front();
                    check_value("ctrl", 64'(want.ctrl), 64'(pipe_out_ctrl_o));
                    check_value("op", want.op, pipe_out_op_o);
                    check_value("mask", want.mask, pipe_out_mask_o);
                end
            end
            if (acc[3]) slot_v[3] = slot_v[2];
            if (acc[2]) slot_v[2] = slot_v[1];
            if (acc[1]) begin
                slot_v[1]  = pipe_in_valid_i;
                slot1_rd   = pipe_in_op_load_i && pipe_in_flags_i.vreg;
                slot1_addr = pipe_in_vaddr_i;
            end
        end
    end

    task automatic fill_regfile();
        for (int a = 0; a < `VREG_CNT; a++) regs[a] = {$urandom, $urandom ^ 32'(a)};
        vreg_rd_v0_i = {$urandom, $urandom};
    endtask

    // kind 0 plain, 1 narrow, 2 scalar, 3 mixed
    task automatic run_phase(input string name, input int n, input int kind, input bit stall);
        logic [1:0] e;
        int         gap;
        cur_test   = name;
        stall_mode = stall;
        fill_regfile();  // pipeline is empty here
        for (int k = 0; k < n; k++) begin
            gap = stall ? $urandom_range(0, 3) : 0;
            if (gap > 0) begin
                pipe_in_valid_i = 1'b0;
                repeat (gap) begin
                    @(posedge clk_i);
                    #1;
                end
            end
            e = 2'($urandom_range(kind == 1 ? 1 : 0, 2));
            pipe_in_eew_i          = eew_e'(e);
            pipe_in_ctrl_i         = 8'($urandom);
            pipe_in_vaddr_i        = 5'($urandom);
            pipe_in_xval_i         = $urandom;
            pipe_in_op_load_i      = (kind < 2) || (($urandom % 4) != 0);
            pipe_in_mask_load_i    = 1'b1;
            pipe_in_flags_i.vreg   = (kind < 2) || (kind == 3 && ($urandom % 2) != 0);
            pipe_in_flags_i.narrow = (kind == 1) || (kind == 3 && ($urandom % 2) != 0);
            pipe_in_flags_i.sigext = ($urandom % 2) != 0;
            pipe_in_valid_i        = 1'b1;
            do @(negedge clk_i); while (!pipe_in_ready_o);
            @(posedge clk_i);
            #1;
        end
        pipe_in_valid_i = 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        #1;
    endtask

    initial begin
        void'($urandom(32'h43ee));
        async_rst_ni        = 1'b0;
        pipe_in_valid_i     = 1'b0;
        pipe_in_ctrl_i      = '0;
        pipe_in_eew_i       = EEW_8;
        pipe_in_op_load_i   = 1'b0;
        pipe_in_mask_load_i = 1'b0;
        pipe_in_vaddr_i     = '0;
        pipe_in_flags_i     = '0;
        pipe_in_xval_i      = '0;
        stall_mode          = 1'b0;
        cur_test            = "reset";
        fill_regfile();
        repeat (3) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;
        run_phase("plain", 40, 0, 1'b0);   // first phase loads the operand buffer
        run_phase("narrow", 40, 1, 1'b0);
        run_phase("scalar", 40, 2, 1'b0);
        run_phase("stall", 120, 3, 1'b1);
        repeat (4) @(posedge clk_i);
        if (exp_q.size() != 0) $display("%0d expected items were never delivered", exp_q.size());
        $display("errors: %0d value mismatches, %0d protocol errors, %0d undelivered",
                 value_errors, other_errors, exp_q.size());
        if (value_errors + other_errors + exp_q.size() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/vregunpack_pkg.sv
hdl/unpack_stage_if.sv
hdl/unpack_pipeline.sv
hdl/operand_unpack.sv
hdl/mask_unpack.sv
hdl/vregunpack_top.sv
testbench/vregunpack_properties.sv
testbench/vregunpack_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vregunpack_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
